// File: bench/tb_edm_pulse_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_edm_pulse_ctrl;

	import edm_pkg::*;

	localparam int C_ACK_HIGH = 0;
	localparam int C_ACK_LOW = 1;
	localparam int C_WAITING = 2; // res1 charging the gap
	localparam int C_RES_OFF = 3;
	localparam int C_DEION = 4;
	localparam int C_OP_LOW = 5;
	localparam int C_OP_HIGH = 6;

	logic clk = 1'b0;
	logic rst_n;
	logic machine_on;
	pulse_cfg_t cfg;
	logic cfg_req;
	logic cfg_ack;
	logic signed [SAMPLE_W-1:0] sample_current;
	logic signed [SAMPLE_W-1:0] sample_voltage;
	gate_bus_t gates;
	logic is_operation;
	logic is_breakdown;

	int errors = 0;
	int timeouts = 0;
	integer seed = 32'h78b809a8;
	int rnd;
	logic gap_closed;                   // samples show a conducting gap
	logic inject_oc;                    // one sample far above the limit
	discharge_mode_e cur_mode = MODE_BUCK;
	int cur_ton = 0;                    // loaded on-time in cycles

	logic rst_d1 = 1'b0;
	int cyc = 0;
	logic req_d1;
	logic req_d2;
	logic ack_d1;
	logic mon_d1;
	logic oc_d1;
	logic oc_d2;
	logic bd_seen;                      // breakdown since the last deion
	logic op_lost;                      // operation dropped during this res1 run
	int gap_cnt;                        // consecutive samples of a conducting gap
	int res_run;
	logic res_end;
	gate_pair_t b1_prev;
	gate_pair_t b2_prev;
	int b1_start;                       // cycle of the latest buck1 charge start
	gate_pair_t legs [4];

	edm_pulse_ctrl i_edm_pulse_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.machine_on(machine_on),
		.cfg(cfg),
		.cfg_req(cfg_req),
		.cfg_ack(cfg_ack),
		.sample_current(sample_current),
		.sample_voltage(sample_voltage),
		.gates(gates),
		.is_operation(is_operation),
		.is_breakdown(is_breakdown)
	);

	always #2 clk = ~clk;

	assign legs[0] = gates.buck1;
	assign legs[1] = gates.buck2;
	assign legs[2] = gates.res1;
	assign legs[3] = gates.res2;
	assign res_end = (gates.res1 != GATE_HIGH) && (res_run != 0);

	// open-loop schedule, run n of a pulse
	function automatic int charge_for_run(input int n);
		return (n < RISE_PERIODS) ? RISE_CHARGE : STAND_CHARGE;
	endfunction

	function automatic logic cond_met(input int which);
		case (which)
			C_ACK_HIGH: return cfg_ack;
			C_ACK_LOW: return !cfg_ack;
			C_WAITING: return gates.res1 == GATE_HIGH;
			C_RES_OFF: return gates.res1 != GATE_HIGH;
			C_DEION: return gates.deion;
			C_OP_LOW: return !is_operation;
			default: return is_operation;
		endcase
	endfunction

	task automatic wait_for(input int which, input int limit, input string what);
		int n;
		n = 0;
		while (!cond_met(which) && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (!cond_met(which))
		begin
			timeouts++;
			$display("timeout at %0t: no %s within %0d cycles", $time, what, limit);
		end
	endtask

	// four-phase load, host side
	task automatic load_config(input discharge_mode_e new_mode, input int ton, input int toff);
		cfg <= '{mode: new_mode, ton_us: CFG_US_W'(ton), toff_us: CFG_US_W'(toff)};
		cfg_req <= 1'b1;
		@(posedge clk);
		wait_for(C_ACK_HIGH, 20, "cfg_ack rise");
		cfg_req <= 1'b0;
		cur_mode <= new_mode;
		cur_ton <= ton * TICKS_PER_US;
		@(posedge clk);
		wait_for(C_ACK_LOW, 20, "cfg_ack fall");
	endtask

	task automatic run_pulse(input logic with_breakdown);
		wait_for(C_WAITING, 5000, "start of waiting");
		if (with_breakdown)
		begin
			repeat (50) @(posedge clk); // open gap for a while first
			gap_closed <= 1'b1;
		end
		wait_for(C_RES_OFF, 3000, "end of waiting");
		wait_for(C_DEION, 3000, "deion after the pulse");
		gap_closed <= 1'b0;
	endtask

	// ADC samples, random within the band of the gap state
	always @(posedge clk)
	begin
		rnd = $random(seed);
		if (inject_oc)
		begin
			sample_current <= SAMPLE_W'(200);
			sample_voltage <= SAMPLE_W'(100);
		end
		else if (gap_closed)
		begin
			sample_current <= SAMPLE_W'(11 + (rnd & 31)); // 11..42, under the limit
			sample_voltage <= SAMPLE_W'(5);
		end
		else
		begin
			sample_current <= SAMPLE_W'(rnd % 10); // noise only
			sample_voltage <= SAMPLE_W'(100);
		end
	end

	always @(posedge clk)
	begin
		rst_d1 <= rst_n;
		cyc <= cyc + 1;
	end

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
			ack_d1 <= 1'b0;
			mon_d1 <= 1'b0;
			oc_d1 <= 1'b0;
			oc_d2 <= 1'b0;
			bd_seen <= 1'b0;
			op_lost <= 1'b0;
			gap_cnt <= 0;
			res_run <= 0;
			b1_prev <= GATE_OFF;
			b2_prev <= GATE_OFF;
			b1_start <= 0;
		end
		else
		begin
			req_d1 <= cfg_req;
			req_d2 <= req_d1;
			ack_d1 <= cfg_ack;
			mon_d1 <= machine_on;
			oc_d1 <= (sample_current > MAX_CURRENT_LIMIT);
			oc_d2 <= oc_d1;
			if (sample_current > BREAKDOWN_CUR && sample_voltage < BREAKDOWN_VOL)
			begin
				if (gap_cnt < 1000)
					gap_cnt <= gap_cnt + 1;
			end
			else
				gap_cnt <= 0;
			if (gates.deion)
				bd_seen <= 1'b0; // new pulse cycle
			else if (is_breakdown)
				bd_seen <= 1'b1;
			if (gates.res1 == GATE_HIGH)
			begin
				res_run <= res_run + 1;
				if (!is_operation)
					op_lost <= 1'b1;
			end
			else
			begin
				res_run <= 0;
				op_lost <= 1'b0;
			end
			b1_prev <= gates.buck1;
			b2_prev <= gates.buck2;
			if (gates.buck1 == GATE_HIGH && b1_prev != GATE_HIGH)
				b1_start <= cyc;
		end
	end

	reset_values: assert property (@(posedge clk)
		(!rst_n || !rst_d1) |-> (gates == '0 && !is_operation && !cfg_ack))
		else
		begin
			errors++;
			$display("ERROR %0t gates/is_operation/cfg_ack got %h/%b/%b expected 0/0/0",
				$time, gates, is_operation, cfg_ack);
		end

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		(cfg_ack && !ack_d1) |-> req_d1)
		else
		begin
			errors++;
			$display("ERROR %0t cfg_req at ack rise got %b expected 1", $time, req_d1);
		end

	ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		(!cfg_req && !req_d1 && !req_d2) |-> !cfg_ack)
		else
		begin
			errors++;
			$display("ERROR %0t cfg_ack got %b expected 0", $time, cfg_ack);
		end

	operation_follows: assert property (@(posedge clk) disable iff (!rst_n)
		is_operation == (mon_d1 && !oc_d2))
		else
		begin
			errors++;
			$display("ERROR %0t is_operation got %b expected %b", $time, is_operation,
				mon_d1 && !oc_d2);
		end

	// detection needs a persistent gap condition while waiting
	breakdown_persists: assert property (@(posedge clk) disable iff (!rst_n)
		is_breakdown |-> (gap_cnt >= BREAKDOWN_TIME && gates.res1 == GATE_HIGH))
		else
		begin
			errors++;
			$display("ERROR %0t is_breakdown gap run got %0d expected at least %0d", $time,
				gap_cnt, BREAKDOWN_TIME);
		end

	phase_offset: assert property (@(posedge clk) disable iff (!rst_n)
		(gates.buck2 == GATE_HIGH && b2_prev != GATE_HIGH) |-> (cyc - b1_start == HALF_PERIOD))
		else
		begin
			errors++;
			$display("ERROR %0t buck2 start offset got %0d expected %0d", $time,
				cyc - b1_start, HALF_PERIOD);
		end

	// abandoned pulse, waiting ran out
	timeout_length: assert property (@(posedge clk) disable iff (!rst_n)
		(res_end && !bd_seen && !op_lost) |->
		(res_run >= WAIT_BREAKDOWN_MAX + 1 && res_run <= WAIT_BREAKDOWN_MAX + 2))
		else
		begin
			errors++;
			$display("ERROR %0t res1 wait time got %0d expected %0d", $time, res_run,
				WAIT_BREAKDOWN_MAX + 2);
		end

	res_held: assert property (@(posedge clk) disable iff (!rst_n)
		(res_end && bd_seen && !op_lost && cur_mode == MODE_RES) |->
		(res_run >= cur_ton + BREAKDOWN_TIME))
		else
		begin
			errors++;
			$display("ERROR %0t res1 high time got %0d expected at least %0d", $time, res_run,
				cur_ton + BREAKDOWN_TIME);
		end

	buck_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(cur_mode == MODE_RES || !bd_seen) |->
		(gates.buck1 != GATE_HIGH && gates.buck2 != GATE_HIGH))
		else
		begin
			errors++;
			$display("ERROR %0t buck1/buck2 got %b/%b expected no 10", $time, gates.buck1,
				gates.buck2);
		end

	for (genvar i = 0; i < 4; i++)
	begin : g_leg
		int off_run;      // cycles at 00 so far
		gate_pair_t last_on;

		always @(posedge clk or negedge rst_n)
		begin
			if (!rst_n)
			begin
				off_run <= DEAD_TIME;
				last_on <= GATE_OFF;
			end
			else if (legs[i] == GATE_OFF)
			begin
				if (off_run < 1000)
					off_run <= off_run + 1;
			end
			else
			begin
				off_run <= 0;
				last_on <= legs[i];
			end
		end

		no_both_on: assert property (@(posedge clk) legs[i] != 2'b11)
			else
			begin
				errors++;
				$display("ERROR %0t leg %0d got %b expected not 11", $time, i, legs[i]);
			end

		dead_time_kept: assert property (@(posedge clk) disable iff (!rst_n)
			(legs[i] != GATE_OFF && last_on != GATE_OFF && legs[i] != last_on) |->
			(off_run >= DEAD_TIME))
			else
			begin
				errors++;
				$display("ERROR %0t leg %0d dead time got %0d expected %0d", $time, i,
					off_run, DEAD_TIME);
			end
	end

	for (genvar j = 0; j < 2; j++)
	begin : g_buck
		int run_len;
		int run_idx;      // charge run number in this pulse

		always @(posedge clk or negedge rst_n)
		begin
			if (!rst_n)
			begin
				run_len <= 0;
				run_idx <= 0;
			end
			else if (gates.deion)
			begin
				run_len <= 0;
				run_idx <= 0;
			end
			else if (legs[j] == GATE_HIGH)
				run_len <= run_len + 1;
			else if (run_len != 0)
			begin
				run_len <= 0;
				run_idx <= run_idx + 1;
			end
		end

		// on-times are picked so that no run gets cut by the pulse end
		charge_time: assert property (@(posedge clk) disable iff (!rst_n)
			(legs[j] != GATE_HIGH && run_len != 0) |-> (run_len == charge_for_run(run_idx)))
			else
			begin
				errors++;
				$display("ERROR %0t buck%0d high time got %0d expected %0d", $time, j + 1,
					run_len, charge_for_run(run_idx));
			end
	end

	initial
	begin
		rst_n = 1'b0;
		machine_on = 1'b0;
		cfg = '0;
		cfg_req = 1'b0;
		sample_current = '0;
		sample_voltage = '0;
		gap_closed = 1'b0;
		inject_oc = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		load_config(MODE_BUCK, 2, 3);
		machine_on <= 1'b1;
		run_pulse(1'b1);           // one buck period

		machine_on <= 1'b0;
		load_config(MODE_BUCK, 20, 3);
		machine_on <= 1'b1;
		run_pulse(1'b1);           // rise and stand periods, both phases

		machine_on <= 1'b0;
		load_config(MODE_RES, 2, 3);
		machine_on <= 1'b1;
		run_pulse(1'b1);
		run_pulse(1'b0);           // gap never breaks down

		wait_for(C_WAITING, 5000, "start of waiting");
		inject_oc <= 1'b1;
		@(posedge clk);
		inject_oc <= 1'b0;
		wait_for(C_OP_LOW, 10, "operation stop on overcurrent");
		wait_for(C_RES_OFF, 10, "res1 release on overcurrent");
		wait_for(C_DEION, 1000, "deion after overcurrent");
		wait_for(C_OP_HIGH, 10, "operation restart");

		machine_on <= 1'b0;
		repeat (20) @(posedge clk);
		$display("summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/breakdown_detect.sv
`timescale 1ns/100ps
`default_nettype none

module breakdown_detect (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic signed [edm_pkg::SAMPLE_W-1:0] sample_current,
	input wire logic signed [edm_pkg::SAMPLE_W-1:0] sample_voltage,
	input wire edm_pkg::fsm_state_e state,
	output logic is_breakdown
);

	import edm_pkg::*;

	logic [BD_CNT_W-1:0] hold_cnt; // consecutive cycles with the gap condition
	logic gap_cond;

	// current starts flowing while the gap voltage collapses
	assign gap_cond = (sample_current > BREAKDOWN_CUR) && (sample_voltage < BREAKDOWN_VOL);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold_cnt <= '0;
			is_breakdown <= 1'b0;
		end
		else if (state != S_WAIT_BREAKDOWN)
		begin
			hold_cnt <= '0; // only meaningful while waiting
			is_breakdown <= 1'b0;
		end
		else if (gap_cond)
		begin
			if (hold_cnt < BD_CNT_W'(BREAKDOWN_TIME))
				hold_cnt <= hold_cnt + 1'b1;       // saturate at BREAKDOWN_TIME
			if (hold_cnt == BD_CNT_W'(BREAKDOWN_TIME - 1))
				is_breakdown <= 1'b1;               // condition persisted long enough
		end
		else
		begin
			hold_cnt <= '0; // glitch, start over
		end
	end

	// a detection can only come out of the waiting phase
	bd_only_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(is_breakdown) |-> $past(state) == S_WAIT_BREAKDOWN)
		else $error("is_breakdown rose outside S_WAIT_BREAKDOWN");

endmodule

`default_nettype wire

// File: hdl/buck_phase_gen.sv
`timescale 1ns/100ps
`default_nettype none

module buck_phase_gen (
	input wire logic clk,
	input wire logic rst_n,
	input wire edm_pkg::fsm_state_e state,
	input wire logic [edm_pkg::TIME_W-1:0] deion_cycles, // off-time timer from the FSM
	input wire edm_pkg::pulse_timing_t timing,
	output edm_pkg::gate_pair_t buck1,                 // phase 0 leg
	output edm_pkg::gate_pair_t buck2                  // phase 180 leg
);

	import edm_pkg::*;

	logic [BUCK_CNT_W-1:0] ph0_cnt;
	logic [BUCK_CNT_W-1:0] ph180_cnt;   // BUCK_PERIOD means parked
	logic [PERIOD_CNT_W-1:0] period_num;
	logic [BUCK_CNT_W-1:0] charge0;
	logic [BUCK_CNT_W-1:0] charge180;   // charge time taken at phase 180 restart

	// off, charge, off, freewheel within one period
	function automatic gate_pair_t leg_pattern(input logic [BUCK_CNT_W-1:0] c,
		input logic [BUCK_CNT_W-1:0] k);
		if (c < DEAD_TIME)
			return GATE_OFF;
		else if (c < k + DEAD_TIME)
			return GATE_HIGH;
		else if (c < k + 2 * DEAD_TIME)
			return GATE_OFF;
		else
			return GATE_LOW;
	endfunction

	// open-loop schedule, longer charge while current rises
	assign charge0 = (period_num < RISE_PERIODS) ? BUCK_CNT_W'(RISE_CHARGE) :
		BUCK_CNT_W'(STAND_CHARGE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ph0_cnt <= '0;
			ph180_cnt <= BUCK_CNT_W'(BUCK_PERIOD);
			period_num <= '0;
			charge180 <= BUCK_CNT_W'(RISE_CHARGE);
		end
		else if (state == S_BUCK)
		begin
			if (ph0_cnt == BUCK_CNT_W'(BUCK_PERIOD - 1))
			begin
				ph0_cnt <= '0;
				if (period_num != '1)
					period_num <= period_num + 1'b1;
			end
			else
				ph0_cnt <= ph0_cnt + 1'b1;

			if (ph0_cnt == BUCK_CNT_W'(HALF_PERIOD - 1))
			begin
				ph180_cnt <= '0;      // half a period behind phase 0
				charge180 <= charge0;  // same schedule, shifted
			end
			else if (ph180_cnt < BUCK_CNT_W'(BUCK_PERIOD))
				ph180_cnt <= ph180_cnt + 1'b1;
		end
		else
		begin
			ph0_cnt <= '0;
			ph180_cnt <= BUCK_CNT_W'(BUCK_PERIOD); // invalid until first restart
			period_num <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buck1 <= GATE_OFF;
			buck2 <= GATE_OFF;
		end
		else
		begin
			case (state)
				S_BUCK:
				begin
					buck1 <= leg_pattern(ph0_cnt, charge0);
					if (ph180_cnt == BUCK_CNT_W'(BUCK_PERIOD))
						buck2 <= GATE_OFF; // not started yet, no freewheel either
					else
						buck2 <= leg_pattern(ph180_cnt, charge180);
				end
				S_DEION:
				begin
					if (in_deion_edge(deion_cycles, timing.toff_cycles))
					begin
						buck1 <= GATE_OFF; // dead time at both ends of the off-time
						buck2 <= GATE_OFF;
					end
					else
					begin
						buck1 <= GATE_LOW; // drain inductors through low side
						buck2 <= GATE_LOW;
					end
				end
				default:
				begin
					buck1 <= GATE_OFF; // waiting or resistor discharge
					buck2 <= GATE_OFF;
				end
			endcase
		end
	end

	no_shoot_through: assert property (@(posedge clk) disable iff (!rst_n)
		(buck1 != 2'b11) && (buck2 != 2'b11))
		else $error("buck leg with both switches on");

endmodule

`default_nettype wire

// File: hdl/discharge_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module discharge_fsm (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic machine_on,
	input wire logic signed [edm_pkg::SAMPLE_W-1:0] sample_current,
	input wire logic is_breakdown,
	input wire edm_pkg::pulse_timing_t timing,
	output edm_pkg::fsm_state_e state,
	output logic [edm_pkg::TIME_W-1:0] deion_cycles, // cycles spent in S_DEION
	output logic is_operation,
	output edm_pkg::gate_pair_t res1,
	output edm_pkg::gate_pair_t res2,
	output logic deion                               // Qoff deion switch
);

	import edm_pkg::*;

	logic is_overcurrent;
	fsm_state_e state_next;
	logic [TIME_W-1:0] wait_cycles; // time spent waiting for breakdown
	logic [TIME_W-1:0] on_cycles;   // discharge time, buck or res

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			is_overcurrent <= 1'b0;
			is_operation <= 1'b0;
		end
		else
		begin
			is_overcurrent <= (sample_current > MAX_CURRENT_LIMIT);
			is_operation <= machine_on && !is_overcurrent; // overcurrent stops the pulses
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			S_DEION:
				if (deion_cycles >= timing.toff_cycles && is_operation)
					state_next = S_WAIT_BREAKDOWN;
			S_WAIT_BREAKDOWN:
				if (!is_operation || wait_cycles > WAIT_BREAKDOWN_MAX)
					state_next = S_DEION; // abandon this pulse
				else if (is_breakdown)
					state_next = (timing.mode == MODE_RES) ? S_RES : S_BUCK;
			S_BUCK:
				if (on_cycles + 1'b1 >= timing.ton_cycles)
					state_next = S_DEION;
			S_RES:
				if (on_cycles + 1'b1 >= timing.ton_cycles || !is_operation)
					state_next = S_DEION;
			default:
				state_next = S_DEION;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_DEION;
			deion_cycles <= '0;
			wait_cycles <= '0;
			on_cycles <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == S_DEION && state_next == S_DEION)
			begin
				if (deion_cycles < timing.toff_cycles)
					deion_cycles <= deion_cycles + 1'b1; // hold at toff until enabled
			end
			else
				deion_cycles <= '0;
			wait_cycles <= (state == S_WAIT_BREAKDOWN) ? wait_cycles + 1'b1 : '0;
			on_cycles <= (state == S_BUCK || state == S_RES) ? on_cycles + 1'b1 : '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			res1 <= GATE_OFF;
			res2 <= GATE_OFF;
			deion <= 1'b0;
		end
		else
		begin
			case (state)
				S_WAIT_BREAKDOWN, S_RES:
				begin
					res1 <= GATE_HIGH; // gap sees the supply through the resistor
					res2 <= GATE_OFF;
					deion <= 1'b0;
				end
				S_DEION:
				begin
					if (in_deion_edge(deion_cycles, timing.toff_cycles))
					begin
						res1 <= GATE_OFF;
						res2 <= GATE_OFF;
						deion <= 1'b0;
					end
					else
					begin
						res1 <= GATE_LOW;
						res2 <= GATE_LOW;
						deion <= 1'b1; // short the gap to clear it
					end
				end
				default:
				begin
					res1 <= GATE_OFF; // buck discharge owns the gap
					res2 <= GATE_OFF;
					deion <= 1'b0;
				end
			endcase
		end
	end

	// deion never overlaps a high side switch nor follows one directly
	deion_vs_upper: assert property (@(posedge clk) disable iff (!rst_n)
		deion |-> !res1.upper && !res2.upper && $past(!res1.upper && !res2.upper))
		else $error("deion on next to an upper switch");

endmodule

`default_nettype wire

// File: hdl/edm_pkg.sv
`default_nettype none

package edm_pkg;

	localparam int TICKS_PER_US = 100;        // 10 ns clock
	localparam int DEAD_TIME = 10;            // both switches off between on states
	localparam int BUCK_PERIOD = 400;         // 4 us switching period
	localparam int HALF_PERIOD = 200;         // phase 180 offset
	localparam int WAIT_BREAKDOWN_MAX = 2000; // 20 us, then give up on the pulse
	localparam int SAMPLE_W = 16;
	localparam int TIME_W = 32;
	localparam int CFG_US_W = 16;             // host on/off time field

	localparam logic signed [SAMPLE_W-1:0] MAX_CURRENT_LIMIT = 76;
	localparam logic signed [SAMPLE_W-1:0] BREAKDOWN_CUR = 10;
	localparam logic signed [SAMPLE_W-1:0] BREAKDOWN_VOL = 40;
	localparam int BREAKDOWN_TIME = 10;       // cycles the gap condition must persist

	localparam int RISE_CHARGE = 120;         // charge cycles while current builds up
	localparam int STAND_CHARGE = 80;         // charge cycles once current stands
	localparam int RISE_PERIODS = 3;

	localparam int BD_CNT_W = $clog2(BREAKDOWN_TIME + 1);
	localparam int BUCK_CNT_W = $clog2(BUCK_PERIOD + 1); // holds the parked value too
	localparam int PERIOD_CNT_W = 16;

	typedef enum logic {
		MODE_BUCK = 1'b0,
		MODE_RES = 1'b1
	} discharge_mode_e;

	typedef enum logic [1:0] {
		S_DEION = 2'd0,
		S_WAIT_BREAKDOWN = 2'd1,
		S_BUCK = 2'd2,
		S_RES = 2'd3
	} fsm_state_e;

	typedef struct packed {
		logic upper; // high side switch
		logic lower; // low side switch
	} gate_pair_t;

	localparam gate_pair_t GATE_OFF = 2'b00;
	localparam gate_pair_t GATE_HIGH = 2'b10;
	localparam gate_pair_t GATE_LOW = 2'b01;

	typedef struct packed {
		discharge_mode_e mode;
		logic [CFG_US_W-1:0] ton_us;
		logic [CFG_US_W-1:0] toff_us;
	} pulse_cfg_t;

	typedef struct packed {
		discharge_mode_e mode;
		logic [TIME_W-1:0] ton_cycles;
		logic [TIME_W-1:0] toff_cycles;
	} pulse_timing_t;

	typedef struct packed {
		gate_pair_t buck1;
		gate_pair_t buck2;
		gate_pair_t res1;
		gate_pair_t res2;
		logic deion;
	} gate_bus_t;

	// first or last dead-time window of the off-time
	function automatic logic in_deion_edge(input logic [TIME_W-1:0] t,
		input logic [TIME_W-1:0] toff);
		return (t < DEAD_TIME) || (t + DEAD_TIME >= toff);
	endfunction

endpackage

`default_nettype wire

// File: hdl/edm_pulse_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module edm_pulse_ctrl (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic machine_on,
	input wire edm_pkg::pulse_cfg_t cfg,
	input wire logic cfg_req,
	output logic cfg_ack,
	input wire logic signed [edm_pkg::SAMPLE_W-1:0] sample_current,
	input wire logic signed [edm_pkg::SAMPLE_W-1:0] sample_voltage,
	output edm_pkg::gate_bus_t gates,
	output logic is_operation,
	output logic is_breakdown
);

	import edm_pkg::*;

	pulse_timing_t timing;
	fsm_state_e state;
	logic [TIME_W-1:0] deion_cycles;
	gate_pair_t buck1;
	gate_pair_t buck2;
	gate_pair_t res1;
	gate_pair_t res2;
	logic deion;

	assign gates = '{buck1: buck1, buck2: buck2, res1: res1, res2: res2, deion: deion};

	pulse_config i_pulse_config (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.cfg_req(cfg_req),
		.cfg_ack(cfg_ack),
		.timing(timing)
	);

	discharge_fsm i_discharge_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.machine_on(machine_on),
		.sample_current(sample_current),
		.is_breakdown(is_breakdown),
		.timing(timing),
		.state(state),
		.deion_cycles(deion_cycles),
		.is_operation(is_operation),
		.res1(res1),
		.res2(res2),
		.deion(deion)
	);

	breakdown_detect i_breakdown_detect (
		.clk(clk),
		.rst_n(rst_n),
		.sample_current(sample_current),
		.sample_voltage(sample_voltage),
		.state(state),
		.is_breakdown(is_breakdown)
	);

	buck_phase_gen i_buck_phase_gen (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.deion_cycles(deion_cycles),
		.timing(timing),
		.buck1(buck1),
		.buck2(buck2)
	);

endmodule

`default_nettype wire

// File: hdl/pulse_config.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_config (
	input wire logic clk,
	input wire logic rst_n,
	input wire edm_pkg::pulse_cfg_t cfg,        // host settings, stable while cfg_req
	input wire logic cfg_req,
	output logic cfg_ack,
	output edm_pkg::pulse_timing_t timing       // settings in clock cycles
);

	import edm_pkg::*;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg_ack <= 1'b0;
			timing <= '{mode: MODE_BUCK, ton_cycles: '0, toff_cycles: '0};
		end
		else if (cfg_req && !cfg_ack)
		begin
			cfg_ack <= 1'b1; // request seen, take the settings
			timing.mode <= cfg.mode;
			timing.ton_cycles <= TIME_W'(cfg.ton_us) * TIME_W'(TICKS_PER_US);  // us to cycles
			timing.toff_cycles <= TIME_W'(cfg.toff_us) * TIME_W'(TICKS_PER_US);
		end
		else if (!cfg_req && cfg_ack)
		begin
			cfg_ack <= 1'b0; // return to idle
		end
	end

	// ack only answers a request that was up on the previous edge
	ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> $past(cfg_req))
		else $error("cfg_ack rose without cfg_req");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the EDM pulse controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_edm_pulse_ctrl -f sim.f

./obj_dir/Vtb_edm_pulse_ctrl > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: sim.f
hdl/edm_pkg.sv
hdl/pulse_config.sv
hdl/breakdown_detect.sv
hdl/buck_phase_gen.sv
hdl/discharge_fsm.sv
hdl/edm_pulse_ctrl.sv
bench/tb_edm_pulse_ctrl.sv
